//--- Makefile
VERILATOR ?= verilator
TOP       ?= pfu_gsdb_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/pfu_gsdb_checks.sv
/*
  Stride detector checker
  Cycle model of the detector with assertions against the DUT outputs
*/
module pfu_gsdb_checks
  import lsu_pipe_pkg::*;
  import pfu_gsdb_pkg::*;
(
  input logic            pfu_gsdb_clk,
  input logic            cpurst_b,
  input ld_da_req_t      ld_da,
  input rtu_commit_vec_t commit,
  input logic            flush,
  input logic            pref_en,
  input logic            gpfb_vld,
  input logic            pop_all_vld,
  input gpfb_req_t       gpfb
);
  timeunit 1ns;
  timeprecision 1ps;

  int          fail_cnt = 0;
  gsdb_state_e m_state;
  logic        m_nvld, m_ncmit, m_base_vld, m_cvld, m_cnorm, m_csucc;
  iid_t        m_niid;
  va_t         m_base;
  va_t         m_diff;
  longint      m_stride, m_ds, m_mag;
  int          m_conf;
  logic        older, gsdb, create, act, normal, succ, hit, miss, keep, set, cmit;
  logic        exp_create, exp_pop, exp_neg;
  stride_t     exp_stride;

  // ==========================================================================
  // Combinational part of the model
  // ==========================================================================
  always_comb
  begin
    if (m_niid[6] == ld_da.iid[6])
      older = m_nvld && ((m_niid[5:0] < ld_da.iid[5:0]) || m_ncmit);
    else
      older = m_nvld && ((m_niid[5:0] > ld_da.iid[5:0]) || m_ncmit);
    cmit = 1'b0;
    for (int i = 0; i < 3; i++)
      if (commit[i].vld && commit[i].iid == m_niid)
        cmit = 1'b1;
    gsdb   = m_state != IDLE;
    create = !gsdb && pref_en;
    set    = gsdb && ld_da.pf_inst_vld && (!m_nvld || older);
    act    = gsdb && ld_da.pf_inst_vld && older && (m_state != GET_STRIDE || ld_da.act_vld);
    m_diff = ld_da.va - m_base;
    m_ds   = longint'($signed(m_diff));
    m_mag  = (m_ds < 0) ? -m_ds : m_ds;
    normal = (m_ds != 0) && (m_mag < 2048);
    succ   = m_ds == m_stride;
    hit    = m_cvld && m_csucc;
    miss   = m_cvld && !m_csucc;
    keep   = (m_state == MONITOR_STRIDE) && gpfb_vld && (m_conf != 0);
    exp_create = (m_state == CHECK_STRIDE) && hit;
    exp_pop    = (m_state == MONITOR_STRIDE) && miss && (m_conf == 0);
    exp_neg    = m_stride < 0;
    exp_stride = stride_t'((m_stride < 0) ? -m_stride : m_stride);
  end

  // Model registers
  always_ff @(posedge pfu_gsdb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      m_state <= IDLE;
      m_nvld <= 1'b0;
      m_ncmit <= 1'b0;
      m_base_vld <= 1'b0;
      m_cvld <= 1'b0;
      m_stride <= 0;
      m_conf <= 0;
    end
    else
    begin
      if (pop_all_vld)
        m_state <= IDLE;
      else if (m_state == IDLE && create)
        m_state <= GET_STRIDE;
      else if (m_state == GET_STRIDE && m_cvld && m_cnorm)
        m_state <= CHECK_STRIDE;
      else if (m_state == CHECK_STRIDE && m_cvld)
        m_state <= hit ? MONITOR_STRIDE : GET_STRIDE;
      else if (m_state == MONITOR_STRIDE && ((miss && m_conf == 0) || (m_cvld && !gpfb_vld)))
        m_state <= GET_STRIDE;
      if (create || (flush && !m_ncmit))
        m_nvld <= 1'b0;
      else if (set)
        m_nvld <= 1'b1;
      if (set)
        m_niid <= ld_da.iid;
      if (set)
        m_ncmit <= 1'b0;
      else if (m_nvld && cmit)
        m_ncmit <= 1'b1;
      if (create)
        m_base_vld <= 1'b0;
      else if (act)
        m_base_vld <= 1'b1;
      if (act)
        m_base <= ld_da.va;
      if (act && m_base_vld && normal && !keep)
        m_stride <= m_ds;
      m_cvld  <= act && m_base_vld;
      m_cnorm <= normal;
      m_csucc <= succ;
      if (m_state == CHECK_STRIDE && hit)
        m_conf <= 2;
      else if (m_state == MONITOR_STRIDE && miss && m_conf != 0)
        m_conf <= m_conf - 1;
      else if (m_state == MONITOR_STRIDE && hit && m_conf != 3)
        m_conf <= m_conf + 1;
    end
  end

  // ==========================================================================
  // Output checks
  // ==========================================================================
  a_create: assert property (@(posedge pfu_gsdb_clk) disable iff (!cpurst_b)
    gpfb.create_vld == exp_create)
  else
  begin
    fail_cnt++;
    $display("CHECK FAILED %s create_vld expected %0b actual %0b",
             pfu_gsdb_tb.test_name, exp_create, gpfb.create_vld);
  end

  a_pop: assert property (@(posedge pfu_gsdb_clk) disable iff (!cpurst_b)
    gpfb.pop_req == exp_pop)
  else
  begin
    fail_cnt++;
    $display("CHECK FAILED %s pop_req expected %0b actual %0b",
             pfu_gsdb_tb.test_name, exp_pop, gpfb.pop_req);
  end

  a_stride: assert property (@(posedge pfu_gsdb_clk) disable iff (!cpurst_b)
    gpfb.stride == exp_stride && gpfb.stride_neg == exp_neg)
  else
  begin
    fail_cnt++;
    $display("CHECK FAILED %s stride expected %0d/%0b actual %0d/%0b",
             pfu_gsdb_tb.test_name, exp_stride, exp_neg, gpfb.stride, gpfb.stride_neg);
  end

endmodule

//--- dv/pfu_gsdb_tb.sv
/*
  Stride detector testbench
  Directed load streams with random strides, checked by pfu_gsdb_checks
*/
module pfu_gsdb_tb
  import lsu_pipe_pkg::*;
  import pfu_gsdb_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_TESTS     = 6;
  localparam int TEST_CYCLES = 60;
  localparam int MARGIN      = 40;

  logic            pfu_gsdb_clk;
  logic            cpurst_b;
  ld_da_req_t      ld_da;
  rtu_commit_vec_t commit;
  logic            flush, pref_en, gpfb_vld, pop_all_vld;
  gpfb_req_t       gpfb;

  string           test_name = "reset";
  int              next_iid = 0;
  va_t             cur_va = 40'h10_0000_0000;
  logic [31:0]     rng = 32'd57423;
  int              fails_before, tests_failed = 0;

  pfu_gsdb_top u_dut (.*);
  pfu_gsdb_checks u_checks (.*);

  initial
  begin
    pfu_gsdb_clk = 1'b0;
    forever
      #50 pfu_gsdb_clk = ~pfu_gsdb_clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic step();
    @(posedge pfu_gsdb_clk);
    #10;
  endtask

  // One pf load per cycle at a fixed stride
  task automatic stream(input int n, input longint stride);
    for (int i = 0; i < n; i++)
    begin
      cur_va = cur_va + va_t'(stride);
      ld_da = '{pf_inst_vld: 1'b1, act_vld: 1'b1, iid: iid_t'(next_iid), va: cur_va};
      next_iid++;
      step();
    end
    ld_da.pf_inst_vld = 1'b0;
  endtask

  // Back to IDLE, then one create cycle into GET_STRIDE
  task automatic restart();
    pop_all_vld = 1'b1;
    step();
    pop_all_vld = 1'b0;
    step();
  endtask

  task automatic start_test(input string name);
    test_name = name;
    fails_before = u_checks.fail_cnt;
  endtask

  task automatic end_test();
    int n;
    step();
    step();
    n = u_checks.fail_cnt - fails_before;
    if (n != 0)
      tests_failed++;
    $display("test %s: %s (%0d errors)", test_name, (n == 0) ? "ok" : "failed", n);
  endtask

  function automatic longint rand_stride();
    rng = xorshift(rng);
    return 1 + longint'(rng % 2047);
  endfunction

  // Watchdog
  initial
  begin
    repeat (N_TESTS * TEST_CYCLES + MARGIN) @(posedge pfu_gsdb_clk);
    $display("Run stopped by watchdog, tests did not complete in time");
    $display(">>> FAIL");
    $finish;
  end

  initial
  begin
    longint s;
    cpurst_b = 1'b0;
    ld_da = '0;
    commit = '0;
    flush = 1'b0;
    pref_en = 1'b0;
    gpfb_vld = 1'b0;
    pop_all_vld = 1'b0;
    repeat (4) @(posedge pfu_gsdb_clk);
    #10 cpurst_b = 1'b1;

    start_test("idle_quiet");
    stream(8, 64);
    end_test();

    start_test("positive_stride");
    pref_en = 1'b1;
    gpfb_vld = 1'b1;
    step();
    stream(6, rand_stride());
    end_test();

    start_test("negative_abnormal");
    restart();
    stream(6, -rand_stride());
    restart();
    stream(6, 0);
    restart();
    stream(6, 4096);
    end_test();

    start_test("confidence_drain");
    restart();
    s = rand_stride();
    stream(4, s);
    for (int i = 1; i <= 4; i++)
      stream(1, s + 8 * i);
    end_test();

    start_test("ooo_and_flush");
    restart();
    s = rand_stride();
    stream(2, s);
    // Older iid than the tracked one
    ld_da = '{pf_inst_vld: 1'b1, act_vld: 1'b1, iid: iid_t'(next_iid - 2), va: cur_va};
    step();
    stream(1, s);
    ld_da.pf_inst_vld = 1'b0;
    flush = 1'b1;
    step();
    flush = 1'b0;
    stream(4, s);
    restart();
    stream(2, s);
    commit[0] = '{vld: 1'b1, iid: iid_t'(next_iid - 1)};
    step();
    commit = '0;
    flush = 1'b1;
    step();
    flush = 1'b0;
    stream(3, s);
    end_test();

    start_test("pop_all_restart");
    restart();
    s = rand_stride();
    stream(5, s);
    restart();
    stream(6, s);
    end_test();

    $display("tests run %0d, tests failed %0d, check failures %0d",
             N_TESTS, tests_failed, u_checks.fail_cnt);
    if (u_checks.fail_cnt == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- hw/lsu_pipe_pkg.sv
/*
  Load/store pipeline types
  Instruction IDs, virtual addresses, data-access load and retire commit ports
*/
`include "pfu_gsdb_consts.svh"

package lsu_pipe_pkg;

  // ==========================================================================
  // Basic vectors
  // ==========================================================================
  typedef logic [`PFU_IID_W-1:0] iid_t;
  typedef logic [`PFU_VA_W-1:0]  va_t;

  // ==========================================================================
  // Load at the data-access stage
  // ==========================================================================
  typedef struct packed {
    // Prefetch-eligible load present
    logic pf_inst_vld;
    // Load really went to memory
    logic act_vld;
    iid_t iid;
    va_t  va;
  } ld_da_req_t;

  // ==========================================================================
  // Retire commit ports
  // ==========================================================================
  typedef struct packed {
    logic vld;
    iid_t iid;
  } rtu_commit_t;

  // All commit ports of one cycle
  typedef rtu_commit_t [`PFU_COMMIT_PORTS-1:0] rtu_commit_vec_t;

endpackage

//--- hw/pfu_gsdb_consts.svh
/*
  Global stride detector constants
  Widths, retire port count and confidence settings
*/
`ifndef PFU_GSDB_CONSTS_SVH
`define PFU_GSDB_CONSTS_SVH

// Instruction ID, top bit is the wrap bit
`define PFU_IID_W         7
`define PFU_VA_W          40

// Largest usable stride magnitude is 2**PFU_STRIDE_W - 1
`define PFU_STRIDE_W      11
`define PFU_COMMIT_PORTS  3

// Pop confidence counter
`define PFU_CONF_W        2
`define PFU_CONF_RELOAD   2

`endif

//--- hw/pfu_gsdb_ctrl.sv
/*
  Stride detector control
  State machine, pop confidence counter, load acceptance and gpfb strobes
*/
`include "pfu_gsdb_consts.svh"

module pfu_gsdb_ctrl
  import lsu_pipe_pkg::*;
  import pfu_gsdb_pkg::*;
(
  input  logic       pfu_gsdb_clk,
  input  logic       cpurst_b,
  input  ld_da_req_t ld_da,
  input  logic       newest_older,
  input  cmp_info_t  cmp_info,
  input  logic       pref_en,
  input  logic       gpfb_vld,
  input  logic       pop_all_vld,
  output logic       gsdb_vld,
  output logic       create,
  output logic       addr_act,
  output logic       stride_keep,
  output logic       create_vld,
  output logic       pop_req
);

  gsdb_state_e cur_state;
  gsdb_state_e nxt_state;
  conf_t       conf;

  logic is_get;
  logic is_check;
  logic is_monitor;
  logic conf_min;
  logic conf_max;
  logic hit;
  logic miss;

  assign is_get     = cur_state == GET_STRIDE;
  assign is_check   = cur_state == CHECK_STRIDE;
  assign is_monitor = cur_state == MONITOR_STRIDE;
  assign conf_min   = conf == '0;
  assign conf_max   = conf == '1;

  assign hit  = cmp_info.vld && cmp_info.success;
  assign miss = cmp_info.vld && !cmp_info.success;

  // ==========================================================================
  // Detection state machine
  // ==========================================================================
  always_ff @(posedge pfu_gsdb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cur_state <= IDLE;
    else if (pop_all_vld)
      cur_state <= IDLE;
    else
      cur_state <= nxt_state;
  end

  always_comb
  begin
    nxt_state = cur_state;
    case (cur_state)
      IDLE:
        if (create)
          nxt_state = GET_STRIDE;
      GET_STRIDE:
        if (cmp_info.vld && cmp_info.normal)
          nxt_state = CHECK_STRIDE;
      CHECK_STRIDE:
        if (hit)
          nxt_state = MONITOR_STRIDE;
        else if (miss)
          nxt_state = GET_STRIDE;
      MONITOR_STRIDE:
        // Broken stride with no confidence left, or buffer entry gone
        if ((miss && conf_min) || (cmp_info.vld && !gpfb_vld))
          nxt_state = GET_STRIDE;
      default:
        nxt_state = IDLE;
    endcase
  end

  assign gsdb_vld = cur_state != IDLE;
  assign create   = !gsdb_vld && pref_en;

  // Loads in get stride must really have accessed memory
  assign addr_act = gsdb_vld
                    && ld_da.pf_inst_vld
                    && newest_older
                    && (!is_get || ld_da.act_vld);

  // ==========================================================================
  // Pop confidence
  // ==========================================================================
  always_ff @(posedge pfu_gsdb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      conf <= '0;
    else if (is_check && hit)
      conf <= conf_t'(`PFU_CONF_RELOAD);
    else if (is_monitor && miss && !conf_min)
      conf <= conf - conf_t'(1);
    else if (is_monitor && hit && !conf_max)
      conf <= conf + conf_t'(1);
  end

  assign stride_keep = is_monitor && gpfb_vld && !conf_min;

  // gpfb strobes
  assign create_vld = is_check && hit;
  assign pop_req    = is_monitor && miss && conf_min;

  // Reloaded confidence blocks a pop right after a create
  a_strobe_excl: assert property (@(posedge pfu_gsdb_clk) disable iff (!cpurst_b)
    create_vld |=> !pop_req);

  // Confidence drains one step at a time down to a pop
  a_pop_conf_zero: assert property (@(posedge pfu_gsdb_clk) disable iff (!cpurst_b)
    pop_req |-> conf_min && ($past(conf) <= conf_t'(1)));

endmodule

//--- hw/pfu_gsdb_inst_track.sv
/*
  Newest prefetch instruction tracker
  Holds the youngest pf load seen, compares its age with the incoming load
  and follows commits and flushes from the retire unit
*/
`include "pfu_gsdb_consts.svh"

module pfu_gsdb_inst_track
  import lsu_pipe_pkg::*;
(
  input  logic            pfu_gsdb_clk,
  input  logic            cpurst_b,
  input  ld_da_req_t      ld_da,
  input  rtu_commit_vec_t commit,
  input  logic            flush,
  input  logic            gsdb_vld,
  input  logic            create,
  output logic            newest_older
);

  logic newest_vld;
  logic newest_cmit;
  iid_t newest_iid;

  logic same_wrap;
  logic iid_older;
  logic cmit_hit;
  logic newest_set;
  logic flush_uncmit;

  // ==========================================================================
  // Age compare with wrap bit
  // ==========================================================================
  assign same_wrap = newest_iid[`PFU_IID_W-1] == ld_da.iid[`PFU_IID_W-1];
  // Same lap, lower index older; different lap, higher index older
  assign iid_older = same_wrap
                     ? (newest_iid[`PFU_IID_W-2:0] < ld_da.iid[`PFU_IID_W-2:0])
                     : (newest_iid[`PFU_IID_W-2:0] > ld_da.iid[`PFU_IID_W-2:0]);

  assign newest_older = newest_vld && (iid_older || newest_cmit);

  // Any commit port retiring the tracked load
  always_comb
  begin
    cmit_hit = 1'b0;
    for (int i = 0; i < `PFU_COMMIT_PORTS; i++)
    begin
      if (commit[i].vld && (commit[i].iid == newest_iid))
        cmit_hit = 1'b1;
    end
  end

  assign newest_set   = gsdb_vld && ld_da.pf_inst_vld && (!newest_vld || newest_older);
  assign flush_uncmit = flush && !newest_cmit;

  // ==========================================================================
  // Tracker registers
  // ==========================================================================
  always_ff @(posedge pfu_gsdb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      newest_vld <= 1'b0;
    else if (create || flush_uncmit)
      newest_vld <= 1'b0;
    else if (newest_set)
      newest_vld <= 1'b1;
  end

  always_ff @(posedge pfu_gsdb_clk)
  begin
    if (newest_set)
      newest_iid <= ld_da.iid;
  end

  // A new load restarts the commit watch
  always_ff @(posedge pfu_gsdb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      newest_cmit <= 1'b0;
    else if (newest_set)
      newest_cmit <= 1'b0;
    else if (newest_vld && cmit_hit)
      newest_cmit <= 1'b1;
  end

  // No new load is taken in a create cycle
  a_create_clears: assert property (@(posedge pfu_gsdb_clk) disable iff (!cpurst_b)
    create |-> !newest_set);

endmodule

//--- hw/pfu_gsdb_pkg.sv
/*
  Global stride detector types
  State encoding, stride and confidence vectors, compare result and gpfb request
*/
`include "pfu_gsdb_consts.svh"

package pfu_gsdb_pkg;

  typedef enum logic [1:0] {
    IDLE           = 2'd0,
    GET_STRIDE     = 2'd1,
    CHECK_STRIDE   = 2'd2,
    MONITOR_STRIDE = 2'd3
  } gsdb_state_e;

  // Stride magnitude, sign travels on its own
  typedef logic [`PFU_STRIDE_W-1:0] stride_t;
  typedef logic [`PFU_CONF_W-1:0]   conf_t;

  // Result of one accepted load, one cycle after acceptance
  typedef struct packed {
    logic vld;
    logic normal;
    logic success;
  } cmp_info_t;

  // Toward the global prefetch buffer
  typedef struct packed {
    logic    create_vld;
    logic    pop_req;
    stride_t stride;
    logic    stride_neg;
  } gpfb_req_t;

endpackage

//--- hw/pfu_gsdb_stride_cmp.sv
/*
  Stride compare
  Keeps the base address and stored signed stride, and registers the
  difference check of each accepted load into the result stage
*/
`include "pfu_gsdb_consts.svh"

module pfu_gsdb_stride_cmp
  import lsu_pipe_pkg::*;
  import pfu_gsdb_pkg::*;
(
  input  logic      pfu_gsdb_clk,
  input  logic      cpurst_b,
  input  va_t       va,
  input  logic      addr_act,
  input  logic      create,
  input  logic      stride_keep,
  output cmp_info_t cmp_info,
  output stride_t   stride,
  output logic      stride_neg
);

  logic    base_vld;
  va_t     base_va;

  va_t     diff;
  va_t     diff_mag;
  logic    diff_neg;
  logic    mag_fits;
  logic    diff_normal;
  logic    diff_success;
  logic    diff_act;

  // ==========================================================================
  // Difference against the previous accepted load
  // ==========================================================================
  assign diff     = va - base_va;
  assign diff_neg = diff[`PFU_VA_W-1];
  assign diff_mag = diff_neg ? (~diff + va_t'(1)) : diff;
  // Magnitude below 2**PFU_STRIDE_W
  assign mag_fits = diff_mag[`PFU_VA_W-1:`PFU_STRIDE_W] == '0;

  assign diff_normal  = (diff != '0) && mag_fits;
  // Checked against the stride stored before this load
  assign diff_success = mag_fits
                        && (diff_mag[`PFU_STRIDE_W-1:0] == stride)
                        && (diff_neg == stride_neg);

  // First accepted load after create only sets the base
  assign diff_act = addr_act && base_vld;

  // ==========================================================================
  // Base address
  // ==========================================================================
  always_ff @(posedge pfu_gsdb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      base_vld <= 1'b0;
    else if (create)
      base_vld <= 1'b0;
    else if (addr_act)
      base_vld <= 1'b1;
  end

  always_ff @(posedge pfu_gsdb_clk)
  begin
    if (addr_act)
      base_va <= va;
  end

  // ==========================================================================
  // Stored stride, visible in the result cycle
  // ==========================================================================
  always_ff @(posedge pfu_gsdb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      stride     <= '0;
      stride_neg <= 1'b0;
    end
    else if (diff_act && diff_normal && !stride_keep)
    begin
      stride     <= diff_mag[`PFU_STRIDE_W-1:0];
      stride_neg <= diff_neg;
    end
  end

  // Result stage
  always_ff @(posedge pfu_gsdb_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      cmp_info <= '0;
    else
    begin
      cmp_info.vld     <= diff_act;
      cmp_info.normal  <= diff_normal;
      cmp_info.success <= diff_success;
    end
  end

  // A result comes from a load accepted outside a create cycle
  a_result_follows_act: assert property (@(posedge pfu_gsdb_clk) disable iff (!cpurst_b)
    cmp_info.vld |-> $past(addr_act && !create));

endmodule

//--- hw/pfu_gsdb_top.sv
/*
  Global stride detector
  Tracks prefetch loads, confirms a global stride and drives the gpfb strobes
*/
module pfu_gsdb_top
  import lsu_pipe_pkg::*;
  import pfu_gsdb_pkg::*;
(
  input  logic            pfu_gsdb_clk,
  input  logic            cpurst_b,
  input  ld_da_req_t      ld_da,
  input  rtu_commit_vec_t commit,
  input  logic            flush,
  input  logic            pref_en,
  input  logic            gpfb_vld,
  input  logic            pop_all_vld,
  output gpfb_req_t       gpfb
);

  logic      newest_older;
  logic      gsdb_vld;
  logic      create;
  logic      addr_act;
  logic      stride_keep;
  cmp_info_t cmp_info;

  // ==========================================================================
  // Newest instruction tracker
  // ==========================================================================
  pfu_gsdb_inst_track u_inst_track (
    .pfu_gsdb_clk (pfu_gsdb_clk),
    .cpurst_b     (cpurst_b),
    .ld_da        (ld_da),
    .commit       (commit),
    .flush        (flush),
    .gsdb_vld     (gsdb_vld),
    .create       (create),
    .newest_older (newest_older)
  );

  // Stride compare
  pfu_gsdb_stride_cmp u_stride_cmp (
    .pfu_gsdb_clk (pfu_gsdb_clk),
    .cpurst_b     (cpurst_b),
    .va           (ld_da.va),
    .addr_act     (addr_act),
    .create       (create),
    .stride_keep  (stride_keep),
    .cmp_info     (cmp_info),
    .stride       (gpfb.stride),
    .stride_neg   (gpfb.stride_neg)
  );

  // State machine and strobes
  pfu_gsdb_ctrl u_ctrl (
    .pfu_gsdb_clk (pfu_gsdb_clk),
    .cpurst_b     (cpurst_b),
    .ld_da        (ld_da),
    .newest_older (newest_older),
    .cmp_info     (cmp_info),
    .pref_en      (pref_en),
    .gpfb_vld     (gpfb_vld),
    .pop_all_vld  (pop_all_vld),
    .gsdb_vld     (gsdb_vld),
    .create       (create),
    .addr_act     (addr_act),
    .stride_keep  (stride_keep),
    .create_vld   (gpfb.create_vld),
    .pop_req      (gpfb.pop_req)
  );

endmodule

//--- verilog.f
+incdir+hw
hw/lsu_pipe_pkg.sv
hw/pfu_gsdb_pkg.sv
hw/pfu_gsdb_inst_track.sv
hw/pfu_gsdb_stride_cmp.sv
hw/pfu_gsdb_ctrl.sv
hw/pfu_gsdb_top.sv
dv/pfu_gsdb_checks.sv
dv/pfu_gsdb_tb.sv
